//--- verilog.f
+incdir+verilog
verilog/thread_pkg.sv
verilog/isa_pkg.sv
verilog/pc_controller.sv
verilog/instr_decode.sv
verilog/thread_execute.sv
verilog/result_port.sv
verilog/barrel_core.sv
dv/fetch_model.sv
dv/barrel_core_tb.sv

//--- Makefile
# Verilator build and run for the barrel core testbench.

VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := barrel_core_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/barrel_core_tb.sv
/*
 * Testbench for the barrel core.
 * Clock, reset, credit stimulus, reference model, assertions and reporting.
 */

`timescale 1ns/10ps
`default_nettype none

`include "barrel_config.svh"

module barrel_core_tb;
    import thread_pkg::*;
    import isa_pkg::*;

    localparam int          CREDITS        = `BARREL_CREDITS;
    localparam int          TEST_CYCLES    = 10 + 100 + 40 + 100 + 150;
    localparam int          TIMEOUT_CYCLES = TEST_CYCLES + 200;
    localparam int unsigned RANDOM_SEED    = 32'h0272_f8c9;

    // How a thread's next PC was chosen.
    localparam logic [1:0] KIND_SEQ   = 2'd0;
    localparam logic [1:0] KIND_JUMP  = 2'd1;
    localparam logic [1:0] KIND_RETRY = 2'd2;

    logic   clock;
    logic   rst_n;
    logic   credit_return;
    instr_t instr;
    fetch_t fetch;
    logic   out_valid;
    out_t   out_data;

    // Reference model state.
    thread_id_t exp_thread;
    pc_t        exp_pc   [`BARREL_THREADS];
    acc_t       exp_acc  [`BARREL_THREADS];
    logic [1:0] exp_kind [`BARREL_THREADS];
    fetch_t     stage_fetch;
    fetch_t     ex_fetch;
    instr_t     ex_instr;
    logic       exp_out_valid;
    out_t       exp_out;
    int         model_credits;
    int         sent_count;
    int         returned_count;
    int         annul_count;
    int         jump_count;
    logic       running;
    pc_t        want_pc;
    logic [1:0] want_kind;

    string test_name = "reset";
    int    test_errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;
    int    mark_sent;
    int    mark_annul;
    int    mark_jump;

    barrel_core barrel_core_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr         (instr),
        .credit_return (credit_return),
        .fetch         (fetch),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    fetch_model fetch_model_i (
        .clock (clock),
        .fetch (fetch),
        .instr (instr)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // ----------------------------------------------------------
    // Reference model.
    // ----------------------------------------------------------

    // It mirrors the pipeline. A fetch in cycle n meets its word in n+1 and
    // executes in n+2, so its output is expected in n+3.
    always @(posedge clock) begin : reference_model
        logic took_credit;
        took_credit = 1'b0;
        if (!rst_n) begin
            exp_thread    <= '0;
            for (int i = 0; i < `BARREL_THREADS; i++) begin
                exp_pc[i]   <= '0;
                exp_acc[i]  <= '0;
                exp_kind[i] <= KIND_SEQ;
            end
            stage_fetch    <= '0;
            ex_fetch       <= '0;
            exp_out_valid  <= 1'b0;
            model_credits  <= CREDITS;
            sent_count     <= 0;
            returned_count <= 0;
            annul_count    <= 0;
            jump_count     <= 0;
        end else begin
            if (fetch.valid) begin
                exp_thread <= exp_thread + thread_id_t'(1);
            end
            stage_fetch    <= fetch;
            ex_fetch       <= stage_fetch;
            ex_instr       <= instr;
            exp_out_valid  <= 1'b0;
            sent_count     <= sent_count + int'(out_valid);
            returned_count <= returned_count + int'(credit_return);
            if (ex_fetch.valid) begin
                case (ex_instr.opcode)
                    JMP: begin
                        exp_pc[ex_fetch.thread]   <= pc_t'(ex_instr.operand);
                        exp_kind[ex_fetch.thread] <= KIND_JUMP;
                        jump_count                <= jump_count + 1;
                    end
                    ADDI: begin
                        exp_acc[ex_fetch.thread]  <= exp_acc[ex_fetch.thread]
                                                     + acc_t'(pc_t'(ex_instr.operand));
                        exp_pc[ex_fetch.thread]   <= ex_fetch.pc + pc_t'(1);
                        exp_kind[ex_fetch.thread] <= KIND_SEQ;
                    end
                    OUT: begin
                        // A return pulse in the same cycle makes a credit available.
                        if ((model_credits > 0) || credit_return) begin
                            took_credit               = 1'b1;
                            exp_out_valid             <= 1'b1;
                            exp_out                   <= '{thread: ex_fetch.thread,
                                                           value: exp_acc[ex_fetch.thread]};
                            exp_pc[ex_fetch.thread]   <= ex_fetch.pc + pc_t'(1);
                            exp_kind[ex_fetch.thread] <= KIND_SEQ;
                        end else begin
                            exp_pc[ex_fetch.thread]   <= ex_fetch.pc;
                            exp_kind[ex_fetch.thread] <= KIND_RETRY;
                            annul_count               <= annul_count + 1;
                        end
                    end
                    default: begin
                        exp_pc[ex_fetch.thread]   <= ex_fetch.pc + pc_t'(1);
                        exp_kind[ex_fetch.thread] <= KIND_SEQ;
                    end
                endcase
            end
            model_credits <= model_credits - int'(took_credit) + int'(credit_return);
        end
    end

    always @(posedge clock) begin
        running <= rst_n;
    end

    assign want_pc   = exp_pc[fetch.thread];
    assign want_kind = exp_kind[fetch.thread];

    // ----------------------------------------------------------
    // Checks.
    // ----------------------------------------------------------

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("FAIL %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        test_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR %s: %s", test_name, what);
        test_errors++;
    endtask

    fetch_valid_after_reset: assert property (@(posedge clock) disable iff (!rst_n)
        running |-> fetch.valid)
        else report_problem("fetch was not valid in a cycle after reset");

    fetch_in_turn: assert property (@(posedge clock) disable iff (!rst_n)
        fetch.valid |-> (fetch.thread == exp_thread))
        else report_mismatch("fetch thread", int'($sampled(exp_thread)),
                             int'($sampled(fetch.thread)));

    pc_sequential: assert property (@(posedge clock) disable iff (!rst_n)
        (fetch.valid && (want_kind == KIND_SEQ)) |-> (fetch.pc == want_pc))
        else report_mismatch("sequential pc", int'($sampled(want_pc)),
                             int'($sampled(fetch.pc)));

    pc_after_jump: assert property (@(posedge clock) disable iff (!rst_n)
        (fetch.valid && (want_kind == KIND_JUMP)) |-> (fetch.pc == want_pc))
        else report_mismatch("jump pc", int'($sampled(want_pc)), int'($sampled(fetch.pc)));

    pc_retry: assert property (@(posedge clock) disable iff (!rst_n)
        (fetch.valid && (want_kind == KIND_RETRY)) |-> (fetch.pc == want_pc))
        else report_mismatch("retry pc", int'($sampled(want_pc)), int'($sampled(fetch.pc)));

    out_valid_expected: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid == exp_out_valid)
        else report_mismatch("out_valid", int'($sampled(exp_out_valid)),
                             int'($sampled(out_valid)));

    // Thread tag and value are compared together as one word.
    out_data_expected: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> (out_data == exp_out))
        else report_mismatch("out_data", int'($sampled(exp_out)), int'($sampled(out_data)));

    credits_outstanding: assert property (@(posedge clock) disable iff (!rst_n)
        ((sent_count + int'(out_valid)) - (returned_count + int'(credit_return))) <= CREDITS)
        else report_problem("more outputs sent than credits allow");

    // ----------------------------------------------------------
    // Stimulus and reporting.
    // ----------------------------------------------------------

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        mark_sent   = sent_count;
        mark_annul  = annul_count;
        mark_jump   = jump_count;
    endtask

    // A credit only comes back while one is in use.
    task automatic drive_credits(input int cycles, input int percent);
        repeat (cycles) begin
            @(negedge clock);
            credit_return = (model_credits < CREDITS) && ($urandom_range(99) < percent);
        end
    endtask

    task automatic require(input bit condition, input string what);
        if (!condition) begin
            report_problem(what);
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    initial begin
        rst_n         = 1'b0;
        credit_return = 1'b0;
        void'($urandom(RANDOM_SEED));
        repeat (10) @(negedge clock);
        rst_n = 1'b1;

        start_test("round_robin_flow");
        drive_credits(100, 50);
        require(jump_count > mark_jump, "no JMP was executed");
        require(sent_count > mark_sent, "no output was sent");
        finish_test();

        // Holding credits back drains the counter and forces annulment.
        start_test("credit_starve");
        drive_credits(40, 0);
        require(annul_count > mark_annul, "no OUT was annulled while credits were held");
        finish_test();

        start_test("credit_recover");
        drive_credits(100, 60);
        require(sent_count > mark_sent, "no output after credits were returned");
        finish_test();

        start_test("credit_random");
        drive_credits(150, 30);
        require(sent_count > mark_sent, "no output was sent");
        finish_test();

        $display("tests passed %0d, failed %0d, outputs %0d, annulled %0d",
                 tests_passed, tests_failed, sent_count, annul_count);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Ends a run that overruns the expected test length.
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/fetch_model.sv
/*
 * Instruction memory model for the barrel core testbench.
 * Answers each fetch one cycle later from fixed per-thread programs.
 */

`timescale 1ns/10ps
`default_nettype none

module fetch_model (
    input  wire                     clock,
    input  wire thread_pkg::fetch_t fetch,
    output isa_pkg::instr_t         instr
);
    import thread_pkg::*;
    import isa_pkg::*;

    fetch_t pending;

    function automatic instr_t encode(input opcode_e opcode, input int operand);
        return '{opcode: opcode, spare: 2'b00, operand: 12'(operand)};
    endfunction

    // Each program mixes ADDI and OUT and loops with one JMP to an earlier PC.
    // Addresses outside a program read as NOP.
    function automatic instr_t program_word(input thread_id_t thread, input pc_t pc);
        instr_t word;
        case ({thread, pc})
            {2'd0, 10'd0}: word = encode(ADDI, 5);
            {2'd0, 10'd1}: word = encode(OUT, 0);
            {2'd0, 10'd2}: word = encode(ADDI, 3);
            {2'd0, 10'd3}: word = encode(OUT, 0);
            {2'd0, 10'd4}: word = encode(JMP, 1);
            {2'd1, 10'd0}: word = encode(ADDI, 1);
            {2'd1, 10'd1}: word = encode(ADDI, 2);
            {2'd1, 10'd2}: word = encode(OUT, 0);
            {2'd1, 10'd4}: word = encode(JMP, 0);
            {2'd2, 10'd1}: word = encode(ADDI, 7);
            {2'd2, 10'd2}: word = encode(OUT, 0);
            {2'd2, 10'd3}: word = encode(JMP, 1);
            {2'd3, 10'd0}: word = encode(ADDI, 100);
            {2'd3, 10'd1}: word = encode(OUT, 0);
            {2'd3, 10'd2}: word = encode(OUT, 0);
            {2'd3, 10'd3}: word = encode(ADDI, 9);
            {2'd3, 10'd4}: word = encode(JMP, 2);
            default:       word = encode(NOP, 0);
        endcase
        return word;
    endfunction

    initial begin
        pending = '0;
        instr   = encode(NOP, 0);
    end

    // The fetch of cycle n is held here during cycle n+1.
    always @(posedge clock) begin
        pending <= fetch;
    end

    // The word goes out on the falling edge, so decode sees it at the end of cycle n+1.
    always @(negedge clock) begin
        instr <= pending.valid ? program_word(pending.thread, pending.pc) : encode(NOP, 0);
    end

endmodule

`default_nettype wire

//--- verilog/barrel_core.sv
/*
 * Top level of the four-thread barrel front end.
 * PC controller, decode, execute and output port.
 */

`timescale 1ns/10ps
`default_nettype none

module barrel_core (
    input  wire                  clock,
    input  wire                  rst_n,
    input  wire isa_pkg::instr_t instr,
    input  wire                  credit_return,
    output thread_pkg::fetch_t   fetch,
    output logic                 out_valid,
    output thread_pkg::out_t     out_data
);
    import thread_pkg::*;
    import isa_pkg::*;

    feedback_t feedback;
    decoded_t  op;
    logic      send;
    out_t      send_data;

    // ----------------------------------------------------------
    // Fetch and decode.
    // ----------------------------------------------------------

    // Fetches leave the core and instruction words come back a cycle later.
    pc_controller pc_controller_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .feedback (feedback),
        .fetch    (fetch)
    );

    instr_decode instr_decode_i (
        .clock (clock),
        .rst_n (rst_n),
        .fetch (fetch),
        .instr (instr),
        .op    (op)
    );

    // ----------------------------------------------------------
    // Execute and output.
    // ----------------------------------------------------------

    thread_execute thread_execute_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .op            (op),
        .credit_return (credit_return),
        .feedback      (feedback),
        .send          (send),
        .send_data     (send_data)
    );

    result_port result_port_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .send      (send),
        .send_data (send_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

//--- verilog/result_port.sv
/*
 * Output channel register.
 * Drives accepted OUT values to the outside on a registered interface.
 */

`timescale 1ns/10ps
`default_nettype none

module result_port (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   send,
    input  wire thread_pkg::out_t send_data,
    output logic                  out_valid,
    output thread_pkg::out_t      out_data
);
    import thread_pkg::*;

    // The data register only loads on a send.
    // It keeps the last word while the channel is idle.
    always_ff @(posedge clock) begin
        if (send) begin
            out_data <= send_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
        end
    end

endmodule

`default_nettype wire

//--- verilog/thread_execute.sv
/*
 * Execute stage.
 * Per-thread accumulators, output credit counter, annulment and PC feedback.
 */

`timescale 1ns/10ps
`default_nettype none

`include "barrel_config.svh"

module thread_execute (
    input  wire                      clock,
    input  wire                      rst_n,
    input  wire isa_pkg::decoded_t   op,
    input  wire                      credit_return,
    output thread_pkg::feedback_t    feedback,
    output logic                     send,
    output thread_pkg::out_t         send_data
);
    import thread_pkg::*;
    import isa_pkg::*;

    localparam int CREDIT_BITS = $clog2(`BARREL_CREDITS + 1);

    acc_t                   acc [`BARREL_THREADS];
    logic [CREDIT_BITS-1:0] credits;
    logic                   is_out;
    logic                   have_credit;
    logic                   annul;

    // ----------------------------------------------------------
    // Output decision.
    // ----------------------------------------------------------

    // A credit pulse in this same cycle counts as available.
    assign is_out      = op.valid && (op.opcode == OUT);
    assign have_credit = (credits != '0) || credit_return;
    assign send        = is_out && have_credit;
    assign annul       = is_out && !have_credit;

    // The value sent is the accumulator as left by the thread's earlier turns.
    assign send_data = '{thread: op.thread, value: acc[op.thread]};

    // ----------------------------------------------------------
    // Credit counter.
    // ----------------------------------------------------------

    // Takes one credit per accepted OUT and gives one back per return pulse.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            credits <= CREDIT_BITS'(`BARREL_CREDITS);
        end else begin
            credits <= credits - CREDIT_BITS'(send) + CREDIT_BITS'(credit_return);
        end
    end

    // ----------------------------------------------------------
    // Accumulators.
    // ----------------------------------------------------------

    // ADDI zero-extends its immediate. No other opcode touches the accumulator.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `BARREL_THREADS; i++) begin
                acc[i] <= '0;
            end
        end else if (op.valid && (op.opcode == ADDI)) begin
            acc[op.thread] <= acc[op.thread] + acc_t'(op.operand);
        end
    end

    // ----------------------------------------------------------
    // PC feedback.
    // ----------------------------------------------------------

    // Reaches the PC controller on the cycle its thread's next fetch is formed.
    always_ff @(posedge clock) begin
        feedback.thread      <= op.thread;
        feedback.jump        <= (op.opcode == JMP);
        feedback.jump_target <= op.operand;
        feedback.io_ready    <= !annul;
        if (!rst_n) begin
            feedback.valid <= 1'b0;
        end else begin
            feedback.valid <= op.valid;
        end
    end

    // The outside must never return more credits than it was given.
    credit_count_bounded: assert property (@(posedge clock) disable iff (!rst_n)
        credits <= CREDIT_BITS'(`BARREL_CREDITS))
        else $error("credit count %0d above limit", credits);

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
/*
 * Instruction decode stage.
 * Pairs each returned instruction word with its fetch and registers the result.
 */

`timescale 1ns/10ps
`default_nettype none

`include "barrel_config.svh"

module instr_decode (
    input  wire                     clock,
    input  wire                     rst_n,
    input  wire thread_pkg::fetch_t fetch,
    input  wire isa_pkg::instr_t    instr,
    output isa_pkg::decoded_t       op
);
    import thread_pkg::*;
    import isa_pkg::*;

    fetch_t fetch_q;

    // ----------------------------------------------------------
    // Fetch alignment.
    // ----------------------------------------------------------

    // The memory answers one cycle after the fetch.
    // Holding the fetch for a cycle lines it up with the word it requested.
    always_ff @(posedge clock) begin
        fetch_q.thread <= fetch.thread;
        fetch_q.pc     <= fetch.pc;
        if (!rst_n) begin
            fetch_q.valid <= 1'b0;
        end else begin
            fetch_q.valid <= fetch.valid;
        end
    end

    // ----------------------------------------------------------
    // Decode register.
    // ----------------------------------------------------------

    // Spare bits and the top of the operand field are dropped here.
    always_ff @(posedge clock) begin
        op.thread  <= fetch_q.thread;
        op.pc      <= fetch_q.pc;
        op.opcode  <= instr.opcode;
        op.operand <= instr.operand[`BARREL_PC_BITS-1:0];
        if (!rst_n) begin
            op.valid <= 1'b0;
        end else begin
            op.valid <= fetch_q.valid;
        end
    end

    // The instruction memory must answer every valid fetch with a real opcode.
    decoded_opcode_legal: assert property (@(posedge clock) disable iff (!rst_n)
        op.valid |-> (!$isunknown(op.opcode) && (op.opcode inside {NOP, JMP, ADDI, OUT})))
        else $error("illegal opcode for thread %0d at pc %0d", op.thread, op.pc);

endmodule

`default_nettype wire

//--- verilog/pc_controller.sv
/*
 * Per-thread program counter controller.
 * Round-robin thread counter, PC table, PC selection and fetch register.
 */

`timescale 1ns/10ps
`default_nettype none

`include "barrel_config.svh"

module pc_controller (
    input  wire                        clock,
    input  wire                        rst_n,
    input  wire thread_pkg::feedback_t feedback,
    output thread_pkg::fetch_t         fetch
);
    import thread_pkg::*;

    // Each table entry keeps the PC last issued for a thread and the PC after it.
    // The issued PC is kept so that an annulled instruction can run again.
    typedef struct packed {
        pc_t issued;
        pc_t next;
    } pc_entry_t;

    thread_id_t thread_q;
    pc_entry_t  pc_table [`BARREL_THREADS];
    pc_entry_t  entry;
    pc_t        sel_pc;

    // ----------------------------------------------------------
    // Thread counter.
    // ----------------------------------------------------------

    // Holds the thread whose fetch is being formed this cycle.
    // It shows up on the fetch port one cycle later.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            thread_q <= '0;
        end else if (thread_q == thread_id_t'(`BARREL_THREADS - 1)) begin
            thread_q <= '0;
        end else begin
            thread_q <= thread_q + thread_id_t'(1);
        end
    end

    // ----------------------------------------------------------
    // PC selection.
    // ----------------------------------------------------------

    assign entry = pc_table[thread_q];

    // Feedback for this thread arrives exactly when its next fetch is formed.
    // Without valid feedback the thread just moves on sequentially.
    always_comb begin
        if (!feedback.valid) begin
            sel_pc = entry.next;
        end else if (!feedback.io_ready) begin
            // Annulled, so the same instruction goes out again.
            sel_pc = entry.issued;
        end else if (feedback.jump) begin
            sel_pc = feedback.jump_target;
        end else begin
            sel_pc = entry.next;
        end
    end

    // ----------------------------------------------------------
    // PC table and fetch register.
    // ----------------------------------------------------------

    // All threads start at PC 0 after reset.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `BARREL_THREADS; i++) begin
                pc_table[i] <= '0;
            end
        end else begin
            pc_table[thread_q] <= '{issued: sel_pc, next: sel_pc + pc_t'(1)};
        end
    end

    // The fetch register presents the thread and PC formed this cycle
    // to the instruction memory.
    always_ff @(posedge clock) begin
        fetch.thread <= thread_q;
        fetch.pc     <= sel_pc;
        if (!rst_n) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= 1'b1;
        end
    end

    // Pipeline depth equals thread count, so feedback always lines up with its own thread.
    feedback_thread_aligned: assert property (@(posedge clock) disable iff (!rst_n)
        feedback.valid |-> (feedback.thread == thread_q))
        else $error("feedback for thread %0d arrived on turn of thread %0d",
                    feedback.thread, thread_q);

endmodule

`default_nettype wire

//--- verilog/isa_pkg.sv
/*
 * Instruction set types.
 * Opcode encoding, the 16-bit instruction word and the decoded operation.
 */

`default_nettype none

`include "barrel_config.svh"

package isa_pkg;

    // Two-bit opcode field in the top of the instruction word.
    typedef enum logic [1:0] {
        NOP  = 2'b00,
        JMP  = 2'b01,
        ADDI = 2'b10,
        OUT  = 2'b11
    } opcode_e;

    // Instruction word as returned by the instruction memory.
    // Only the low PC-width bits of the operand are used.
    // They hold a jump target or an immediate.
    typedef struct packed {
        opcode_e     opcode;
        logic [1:0]  spare;
        logic [11:0] operand;
    } instr_t;

    // Operation handed from decode to execute.
    // It carries the thread and PC of the fetch that produced it.
    typedef struct packed {
        logic                      valid;
        thread_pkg::thread_id_t    thread;
        thread_pkg::pc_t           pc;
        opcode_e                   opcode;
        logic [`BARREL_PC_BITS-1:0] operand;
    } decoded_t;

endpackage

`default_nettype wire

//--- verilog/thread_pkg.sv
/*
 * Thread-level types shared by the front end.
 * Thread id, PC, accumulator, fetch request, PC feedback and output word.
 */

`default_nettype none

`include "barrel_config.svh"

package thread_pkg;

    typedef logic [`BARREL_THREAD_BITS-1:0] thread_id_t;
    typedef logic [`BARREL_PC_BITS-1:0]     pc_t;
    typedef logic [`BARREL_ACC_BITS-1:0]    acc_t;

    // One instruction fetch, issued each cycle by the PC controller.
    typedef struct packed {
        logic       valid;
        thread_id_t thread;
        pc_t        pc;
    } fetch_t;

    // Outcome of an executed instruction, returned to the PC controller.
    // A low io_ready means the instruction was annulled and must be re-issued.
    typedef struct packed {
        logic       valid;
        thread_id_t thread;
        logic       jump;
        pc_t        jump_target;
        logic       io_ready;
    } feedback_t;

    // One word on the output channel, tagged with the thread that sent it.
    typedef struct packed {
        thread_id_t thread;
        acc_t       value;
    } out_t;

endpackage

`default_nettype wire

//--- verilog/barrel_config.svh
/*
 * Build-time sizes for the barrel processor front end.
 * Thread count, field widths and the output channel credit limit.
 */

`ifndef BARREL_CONFIG_SVH
`define BARREL_CONFIG_SVH

// Number of hardware threads. The pipeline depth equals this value,
// so every thread sees its own feedback just in time for its next turn.
`define BARREL_THREADS      4
`define BARREL_THREAD_BITS  2

// Instruction address width. PCs wrap at this width.
`define BARREL_PC_BITS      10

// Width of each per-thread accumulator.
`define BARREL_ACC_BITS     16

// Credits the output channel grants after reset.
`define BARREL_CREDITS      2

`endif
